// File: hdl/conv_fetch_defines.svh
`ifndef CONV_FETCH_DEFINES_SVH
`define CONV_FETCH_DEFINES_SVH

// width of every pixel and register index
`define IDX_W 16

// pixels per fetched segment, power of two
`define PIXELS_IN_ROW 32

// line-buffer banks rotated by the issuer
`define BUFFERS_NUM 3
`define BANK_W 2

`endif

// File: hdl/conv_fetch_pkg.sv
`include "conv_fetch_defines.svh"

package conv_fetch_pkg;

   // pixel or register index
   typedef logic [`IDX_W-1:0] pix_idx_t;

   // kernel, stride, padding, pad counts and slab overlap
   typedef logic [3:0] geom_t;

   // tile walker states
   typedef enum logic [1:0] {
      walk_idle,
      walk_run,
      walk_done
   } walker_state_e;

endpackage

// File: hdl/conv_tile_walker.sv
module conv_tile_walker
   import conv_fetch_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     start,
   input  pix_idx_t pox,
   input  pix_idx_t ix,
   input  logic     conv_pixels_add_end,
   output pix_idx_t ox_start,
   output pix_idx_t next_ox_start,
   output logic     en,
   output logic     conv_tiling_add_end,
   output logic     last_tile
);

   walker_state_e state;
   pix_idx_t      ox_after;

   //////////////////////////////
   // tile bookkeeping
   //////////////////////////////

   assign ox_after = ox_start + pox;

   // output width arrives as ix
   assign last_tile = (ox_after > ix);

   // wraps back to the first column once the row is covered
   assign next_ox_start = last_tile ? pix_idx_t'(1) : ox_after;

   assign conv_tiling_add_end = (state == walk_run) && conv_pixels_add_end && last_tile;

   //////////////////////////////
   // state machine
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= walk_idle;
         en       <= 1'b0;
         ox_start <= pix_idx_t'(1);
      end else begin
         en <= 1'b0;
         case (state)
            walk_idle: begin
               if (start) begin
                  state    <= walk_run;
                  en       <= 1'b1;
                  ox_start <= pix_idx_t'(1);
               end
            end
            walk_run: begin
               // step one tile per finished segment group
               if (conv_pixels_add_end) begin
                  ox_start <= next_ox_start;
                  if (last_tile) begin
                     state <= walk_done;
                  end
               end
            end
            walk_done: begin
               state <= walk_idle;
            end
            default: begin
               state <= walk_idle;
            end
         endcase
      end
   end

endmodule

// File: hdl/conv_pixels.sv
`include "conv_fetch_defines.svh"

module conv_pixels
   import conv_fetch_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  logic     en,
   input  logic     conv_tiling_add_end,
   input  pix_idx_t ix,
   input  pix_idx_t ox_start,
   input  pix_idx_t next_ox_start,
   input  pix_idx_t pox,
   input  geom_t    k,
   input  geom_t    s,
   input  geom_t    p,
   output geom_t    west_pad,
   output geom_t    slab_num,
   output geom_t    east_pad,
   output pix_idx_t row_start_idx,
   output pix_idx_t row_end_idx,
   output pix_idx_t reg_start_idx,
   output pix_idx_t reg_end_idx,
   output logic     seg_active,
   output logic     conv_pixels_add_end
);

   localparam pix_idx_t row_len  = pix_idx_t'(`PIXELS_IN_ROW);
   localparam pix_idx_t row_mask = pix_idx_t'(`PIXELS_IN_ROW - 1);

   // first padded input column of a tile, 1-based
   function automatic pix_idx_t first_col(input pix_idx_t ox, input geom_t stride);
      return (stride == 4'd2) ? (ox << 1) - pix_idx_t'(1) : ox;
   endfunction

   function automatic geom_t west_pad_of(input pix_idx_t col, input pix_idx_t pad);
      return (col <= pad) ? geom_t'(pad - col + pix_idx_t'(1)) : geom_t'(0);
   endfunction

   // pixels kept from the previous tile once past the left border
   function automatic geom_t slab_of(input pix_idx_t col, input pix_idx_t pad);
      return (col <= pad + pix_idx_t'(1)) ? geom_t'(0) : geom_t'(pad);
   endfunction

   function automatic geom_t east_pad_of(input pix_idx_t col_end, input pix_idx_t pad,
                                         input pix_idx_t pad_plus_ix);
      pix_idx_t over;
      over = (col_end > pad_plus_ix) ? col_end - pad_plus_ix : pix_idx_t'(0);
      if (over > pad) begin
         over = pad;
      end
      return geom_t'(over);
   endfunction

   // last real pixel, rounded up to a segment boundary and clipped
   function automatic pix_idx_t last_row_idx(input pix_idx_t col_end, input geom_t rpad,
                                             input pix_idx_t pad, input pix_idx_t width);
      pix_idx_t cut;
      pix_idx_t last;
      cut  = pad + pix_idx_t'(rpad) + pix_idx_t'(1);
      last = (col_end >= cut) ? col_end - cut : pix_idx_t'(0);
      last = last | row_mask;
      if (last > width - pix_idx_t'(1)) begin
         last = width - pix_idx_t'(1);
      end
      return last;
   endfunction

   pix_idx_t p_ext;
   pix_idx_t p_plus_ix;
   pix_idx_t tile_span;
   pix_idx_t ix_start;
   pix_idx_t next_ix_start;
   pix_idx_t ix_end;
   pix_idx_t ix_end_min0;
   pix_idx_t ix_end_min;
   geom_t    left_pad;
   geom_t    overlap;
   geom_t    right_pad;
   geom_t    right_pad_min;
   pix_idx_t row_start_fix;
   pix_idx_t row_end_fix;
   pix_idx_t row_end_min_fix;
   pix_idx_t reg_from_initial;
   pix_idx_t next_reg_from_initial;

   logic     active;
   logic     phase2;
   pix_idx_t seg_off;
   pix_idx_t reg_from;

   pix_idx_t base;
   pix_idx_t limit;
   pix_idx_t span;
   logic     need_tail;
   logic     last_in_loop;
   pix_idx_t reg_to;

   //////////////////////////////
   // tile geometry
   //////////////////////////////

   assign p_ext     = pix_idx_t'(p);
   assign p_plus_ix = p_ext + ix;

   // (pox - 1) * s for s of 1 or 2
   assign tile_span = (s == 4'd2) ? (pox - pix_idx_t'(1)) << 1 : pox - pix_idx_t'(1);

   assign ix_start      = first_col(ox_start, s);
   assign next_ix_start = first_col(next_ox_start, s);
   assign ix_end        = ix_start + tile_span + pix_idx_t'(k) - pix_idx_t'(1);
   assign ix_end_min0   = ix_start + tile_span + pix_idx_t'(1);
   assign ix_end_min    = (ix_end_min0 > ix_end) ? ix_end : ix_end_min0;

   assign left_pad      = west_pad_of(ix_start, p_ext);
   assign overlap       = slab_of(ix_start, p_ext);
   assign right_pad     = east_pad_of(ix_end, p_ext, p_plus_ix);
   assign right_pad_min = east_pad_of(ix_end_min, p_ext, p_plus_ix);

   assign row_start_fix   = ix_start + pix_idx_t'(left_pad) + pix_idx_t'(overlap)
                            - (p_ext + pix_idx_t'(1));
   assign row_end_fix     = last_row_idx(ix_end, right_pad, p_ext, ix);
   assign row_end_min_fix = last_row_idx(ix_end_min, right_pad_min, p_ext, ix);

   // registers after pads and retained overlap
   assign reg_from_initial      = pix_idx_t'(left_pad) + pix_idx_t'(overlap) + pix_idx_t'(1);
   assign next_reg_from_initial = pix_idx_t'(west_pad_of(next_ix_start, p_ext))
                                  + pix_idx_t'(slab_of(next_ix_start, p_ext)) + pix_idx_t'(1);

   //////////////////////////////
   // segment walk
   //////////////////////////////

   // second loop covers only the kernel tail
   assign need_tail = (row_end_fix > row_end_min_fix);
   assign base      = phase2 ? row_end_min_fix + pix_idx_t'(1) : row_start_fix;
   assign limit     = phase2 ? row_end_fix : row_end_min_fix;
   assign span      = (base > limit) ? pix_idx_t'(0) : limit - base;

   assign last_in_loop        = active && ((span - seg_off) < row_len);
   assign conv_pixels_add_end = last_in_loop && (phase2 || !need_tail);
   assign seg_active          = active;

   assign row_start_idx = base + seg_off;
   assign row_end_idx   = last_in_loop ? limit : row_start_idx + row_len - pix_idx_t'(1);
   assign reg_to        = reg_from + (row_end_idx - row_start_idx);

   assign west_pad  = (!phase2 && seg_off == '0) ? left_pad : geom_t'(0);
   assign slab_num  = (!phase2 && seg_off == '0) ? overlap : geom_t'(0);
   assign east_pad  = conv_pixels_add_end ? right_pad : geom_t'(0);

   assign reg_start_idx = reg_from;
   assign reg_end_idx   = reg_to + pix_idx_t'(east_pad);

   always_ff @(posedge clk) begin
      if (reset) begin
         active  <= 1'b0;
         phase2  <= 1'b0;
         seg_off <= '0;
      end else if (en) begin
         active   <= 1'b1;
         phase2   <= 1'b0;
         seg_off  <= '0;
         reg_from <= reg_from_initial;
      end else if (active) begin
         if (conv_pixels_add_end) begin
            // next tile starts on the following clock
            phase2   <= 1'b0;
            seg_off  <= '0;
            reg_from <= next_reg_from_initial;
            if (conv_tiling_add_end) begin
               active <= 1'b0;
            end
         end else if (last_in_loop) begin
            phase2   <= 1'b1;
            seg_off  <= '0;
            reg_from <= reg_to + pix_idx_t'(1);
         end else begin
            seg_off  <= seg_off + row_len;
            reg_from <= reg_to + pix_idx_t'(1);
         end
      end
   end

endmodule

// File: hdl/row_fetch_issuer.sv
`include "conv_fetch_defines.svh"

module row_fetch_issuer
   import conv_fetch_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic               seg_active,
   input  logic               conv_pixels_add_end,
   input  logic               last_tile,
   input  pix_idx_t           row_start_idx,
   input  pix_idx_t           row_end_idx,
   input  pix_idx_t           reg_start_idx,
   input  pix_idx_t           reg_end_idx,
   input  geom_t              west_pad,
   input  geom_t              slab_num,
   input  geom_t              east_pad,
   output logic               fetch_valid,
   output logic               tile_end,
   output logic               layer_done,
   output pix_idx_t           fetch_row_start,
   output pix_idx_t           fetch_row_end,
   output pix_idx_t           fetch_reg_start,
   output pix_idx_t           fetch_reg_end,
   output geom_t              fetch_west_pad,
   output geom_t              fetch_east_pad,
   output geom_t              fetch_slab,
   output logic [`BANK_W-1:0] fetch_bank
);

   localparam logic [`BANK_W-1:0] last_bank = `BANK_W'(`BUFFERS_NUM - 1);

   logic [`BANK_W-1:0] tile_bank;
   logic               seg_tile_end;

   assign seg_tile_end = seg_active && conv_pixels_add_end;

   //////////////////////////////
   // strobes and bank rotation
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         fetch_valid <= 1'b0;
         tile_end    <= 1'b0;
         layer_done  <= 1'b0;
         fetch_bank  <= '0;
         tile_bank   <= '0;
      end else begin
         fetch_valid <= seg_active;
         tile_end    <= seg_tile_end;
         layer_done  <= seg_tile_end && last_tile;
         if (seg_active) begin
            fetch_bank <= tile_bank;
         end
         // new layer always begins in bank 0
         if (seg_tile_end) begin
            if (last_tile || tile_bank == last_bank) begin
               tile_bank <= '0;
            end else begin
               tile_bank <= tile_bank + 1'b1;
            end
         end
      end
   end

   //////////////////////////////
   // segment fields
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (seg_active) begin
         fetch_row_start <= row_start_idx;
         fetch_row_end   <= row_end_idx;
         fetch_reg_start <= reg_start_idx;
         fetch_reg_end   <= reg_end_idx;
         fetch_west_pad  <= west_pad;
         fetch_east_pad  <= east_pad;
         fetch_slab      <= slab_num;
      end
   end

endmodule

// File: hdl/conv_fetch_top.sv
`include "conv_fetch_defines.svh"

module conv_fetch_top
   import conv_fetch_pkg::*;
(
   input  logic               clk,
   input  logic               reset,
   input  logic               start,
   input  pix_idx_t           ix,
   input  pix_idx_t           pox,
   input  geom_t              k,
   input  geom_t              s,
   input  geom_t              p,
   output logic               fetch_valid,
   output logic               tile_end,
   output logic               layer_done,
   output pix_idx_t           fetch_row_start,
   output pix_idx_t           fetch_row_end,
   output pix_idx_t           fetch_reg_start,
   output pix_idx_t           fetch_reg_end,
   output geom_t              fetch_west_pad,
   output geom_t              fetch_east_pad,
   output geom_t              fetch_slab,
   output logic [`BANK_W-1:0] fetch_bank
);

   pix_idx_t ox_start;
   pix_idx_t next_ox_start;
   logic     en;
   logic     conv_tiling_add_end;
   logic     last_tile;
   logic     seg_active;
   logic     conv_pixels_add_end;
   pix_idx_t row_start_idx;
   pix_idx_t row_end_idx;
   pix_idx_t reg_start_idx;
   pix_idx_t reg_end_idx;
   geom_t    west_pad;
   geom_t    slab_num;
   geom_t    east_pad;

   // tile stepping along the output row
   conv_tile_walker conv_tile_walker_i (
      .clk                 (clk),
      .reset               (reset),
      .start               (start),
      .pox                 (pox),
      .ix                  (ix),
      .conv_pixels_add_end (conv_pixels_add_end),
      .ox_start            (ox_start),
      .next_ox_start       (next_ox_start),
      .en                  (en),
      .conv_tiling_add_end (conv_tiling_add_end),
      .last_tile           (last_tile)
   );

   conv_pixels conv_pixels_i (
      .clk                 (clk),
      .reset               (reset),
      .en                  (en),
      .conv_tiling_add_end (conv_tiling_add_end),
      .ix                  (ix),
      .ox_start            (ox_start),
      .next_ox_start       (next_ox_start),
      .pox                 (pox),
      .k                   (k),
      .s                   (s),
      .p                   (p),
      .west_pad            (west_pad),
      .slab_num            (slab_num),
      .east_pad            (east_pad),
      .row_start_idx       (row_start_idx),
      .row_end_idx         (row_end_idx),
      .reg_start_idx       (reg_start_idx),
      .reg_end_idx         (reg_end_idx),
      .seg_active          (seg_active),
      .conv_pixels_add_end (conv_pixels_add_end)
   );

   // one register stage to the fetch port
   row_fetch_issuer row_fetch_issuer_i (
      .clk                 (clk),
      .reset               (reset),
      .seg_active          (seg_active),
      .conv_pixels_add_end (conv_pixels_add_end),
      .last_tile           (last_tile),
      .row_start_idx       (row_start_idx),
      .row_end_idx         (row_end_idx),
      .reg_start_idx       (reg_start_idx),
      .reg_end_idx         (reg_end_idx),
      .west_pad            (west_pad),
      .slab_num            (slab_num),
      .east_pad            (east_pad),
      .fetch_valid         (fetch_valid),
      .tile_end            (tile_end),
      .layer_done          (layer_done),
      .fetch_row_start     (fetch_row_start),
      .fetch_row_end       (fetch_row_end),
      .fetch_reg_start     (fetch_reg_start),
      .fetch_reg_end       (fetch_reg_end),
      .fetch_west_pad      (fetch_west_pad),
      .fetch_east_pad      (fetch_east_pad),
      .fetch_slab          (fetch_slab),
      .fetch_bank          (fetch_bank)
   );

endmodule

// File: test/conv_fetch_props.sv
module conv_fetch_props (
   input logic clk,
   input logic reset,
   input logic fetch_valid,
   input logic tile_end,
   input logic layer_done
);

   timeunit 1ns;
   timeprecision 100ps;

   //////////////////////////////
   // fetch strobe protocol
   //////////////////////////////

   // segments stream without gaps until the layer ends
   property valid_until_layer_done;
      @(posedge clk) disable iff (reset)
         (fetch_valid && !layer_done) |=> fetch_valid;
   endproperty

   property markers_need_valid;
      @(posedge clk) disable iff (reset)
         (tile_end || layer_done) |-> fetch_valid;
   endproperty

   // last segment of a layer also closes its tile
   property layer_done_closes_tile;
      @(posedge clk) disable iff (reset)
         layer_done |-> tile_end;
   endproperty

   valid_until_layer_done_a: assert property (valid_until_layer_done)
      else $error("fetch_valid dropped before layer_done");

   markers_need_valid_a: assert property (markers_need_valid)
      else $error("tile_end or layer_done seen without fetch_valid");

   layer_done_closes_tile_a: assert property (layer_done_closes_tile)
      else $error("layer_done seen without tile_end");

endmodule

bind conv_fetch_top conv_fetch_props conv_fetch_props_i (
   .clk         (clk),
   .reset       (reset),
   .fetch_valid (fetch_valid),
   .tile_end    (tile_end),
   .layer_done  (layer_done)
);

// File: test/conv_fetch_tb.sv
`include "conv_fetch_defines.svh"

module conv_fetch_tb
   import conv_fetch_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int num_layers      = 23;
   localparam int directed_layers = 3;
   localparam pix_idx_t row_len   = pix_idx_t'(`PIXELS_IN_ROW);

   typedef struct packed {
      pix_idx_t           row_start;
      pix_idx_t           row_end;
      pix_idx_t           reg_start;
      pix_idx_t           reg_end;
      geom_t              west_pad;
      geom_t              east_pad;
      geom_t              slab;
      logic [`BANK_W-1:0] bank;
      logic               tile_end;
      logic               layer_done;
   } seg_t;

   logic               clk;
   logic               reset;
   logic               start;
   pix_idx_t           ix;
   pix_idx_t           pox;
   geom_t              k;
   geom_t              s;
   geom_t              p;
   logic               fetch_valid;
   logic               tile_end;
   logic               layer_done;
   pix_idx_t           fetch_row_start;
   pix_idx_t           fetch_row_end;
   pix_idx_t           fetch_reg_start;
   pix_idx_t           fetch_reg_end;
   geom_t              fetch_west_pad;
   geom_t              fetch_east_pad;
   geom_t              fetch_slab;
   logic [`BANK_W-1:0] fetch_bank;

   seg_t   expected[$];
   seg_t   want_seg;
   int     lay_ix[num_layers];
   int     lay_pox[num_layers];
   int     lay_k[num_layers];
   int     lay_s[num_layers];
   int     lay_p[num_layers];
   int     error_count;
   int     checked_count;
   int     total_segments;
   int     watchdog_cycles;
   integer seed;
   logic   plan_ready;
   logic   in_layer;

   conv_fetch_top conv_fetch_top_i (
      .clk             (clk),
      .reset           (reset),
      .start           (start),
      .ix              (ix),
      .pox             (pox),
      .k               (k),
      .s               (s),
      .p               (p),
      .fetch_valid     (fetch_valid),
      .tile_end        (tile_end),
      .layer_done      (layer_done),
      .fetch_row_start (fetch_row_start),
      .fetch_row_end   (fetch_row_end),
      .fetch_reg_start (fetch_reg_start),
      .fetch_reg_end   (fetch_reg_end),
      .fetch_west_pad  (fetch_west_pad),
      .fetch_east_pad  (fetch_east_pad),
      .fetch_slab      (fetch_slab),
      .fetch_bank      (fetch_bank)
   );

   always #2 clk = ~clk;

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) begin
         error_count++;
         $display("[FAIL] %0t: %s is %0d, expected %0d", $time, what, got, want);
      end
   endtask

   function automatic int pick_range(input int lo, input int hi);
      int r;
      r = $random(seed);
      return lo + ((r & 32'h7fff_ffff) % (hi - lo + 1));
   endfunction

   //////////////////////////////
   // reference model
   //////////////////////////////

   // padded columns are 1-based, real pixels 0-based
   function automatic geom_t pad_before(input pix_idx_t col, input pix_idx_t pad);
      if (col > pad) begin
         return 4'd0;
      end
      return geom_t'(pad + 16'd1 - col);
   endfunction

   function automatic geom_t overlap_at(input pix_idx_t col, input pix_idx_t pad);
      return (col > pad + 16'd1) ? geom_t'(pad) : 4'd0;
   endfunction

   function automatic geom_t pad_after(input pix_idx_t col_end, input pix_idx_t pad,
                                       input pix_idx_t width);
      pix_idx_t beyond;
      beyond = (col_end > pad + width) ? col_end - pad - width : 16'd0;
      return geom_t'((beyond < pad) ? beyond : pad);
   endfunction

   // last real pixel up to the next segment boundary, inside the row
   function automatic pix_idx_t round_end(input pix_idx_t col_end, input geom_t epad,
                                          input pix_idx_t pad, input pix_idx_t width);
      pix_idx_t px;
      px = (col_end >= pad + 16'(epad) + 16'd1) ? col_end - pad - 16'(epad) - 16'd1 : 16'd0;
      px = px | (row_len - 16'd1);
      return (px > width - 16'd1) ? width - 16'd1 : px;
   endfunction

   function automatic int model_segments(input int g_ix, input int g_pox, input int g_k,
                                         input int g_s, input int g_p);
      pix_idx_t width, tpox, stride, kern, pad, ox, col0, col_last, col_min;
      pix_idx_t lo, hi_min, hi_full, first, stop, span, off, reg_next, seg_lo, seg_hi;
      geom_t    wpad, slab, epad, epad_min;
      seg_t     seg;
      int       tile, count, pass;
      logic     tail, final_tile, seg_last;
      width  = pix_idx_t'(g_ix);
      tpox   = pix_idx_t'(g_pox);
      stride = pix_idx_t'(g_s);
      kern   = pix_idx_t'(g_k);
      pad    = pix_idx_t'(g_p);
      ox     = 16'd1;
      tile   = 0;
      count  = 0;
      do begin
         final_tile = (ox + tpox) > width;
         col0     = ox * stride - stride + 16'd1;
         col_last = col0 + (tpox - 16'd1) * stride + kern - 16'd1;
         col_min  = col0 + (tpox - 16'd1) * stride + 16'd1;
         if (col_min > col_last) begin
            col_min = col_last;
         end
         wpad     = pad_before(col0, pad);
         slab     = overlap_at(col0, pad);
         epad     = pad_after(col_last, pad, width);
         epad_min = pad_after(col_min, pad, width);
         lo       = col0 + 16'(wpad) + 16'(slab) - pad - 16'd1;
         hi_full  = round_end(col_last, epad, pad, width);
         hi_min   = round_end(col_min, epad_min, pad, width);
         tail     = hi_full > hi_min;
         reg_next = 16'(wpad) + 16'(slab) + 16'd1;
         // pass 1 walks the kernel tail only
         for (pass = 0; pass < (tail ? 2 : 1); pass++) begin
            first    = (pass == 1) ? hi_min + 16'd1 : lo;
            stop     = (pass == 1) ? hi_full : hi_min;
            span     = (first > stop) ? 16'd0 : stop - first;
            off      = 16'd0;
            seg_last = 1'b0;
            while (!seg_last) begin
               seg_last       = (span - off) < row_len;
               seg_lo         = first + off;
               seg_hi         = seg_last ? stop : seg_lo + row_len - 16'd1;
               seg.row_start  = seg_lo;
               seg.row_end    = seg_hi;
               seg.west_pad   = (pass == 0 && off == 16'd0) ? wpad : 4'd0;
               seg.slab       = (pass == 0 && off == 16'd0) ? slab : 4'd0;
               seg.tile_end   = seg_last && (pass == 1 || !tail);
               seg.east_pad   = seg.tile_end ? epad : 4'd0;
               seg.reg_start  = reg_next;
               seg.reg_end    = reg_next + (seg_hi - seg_lo) + 16'(seg.east_pad);
               seg.layer_done = seg.tile_end && final_tile;
               seg.bank       = `BANK_W'(tile % `BUFFERS_NUM);
               expected.push_back(seg);
               count++;
               reg_next = reg_next + (seg_hi - seg_lo) + 16'd1;
               off      = off + row_len;
            end
         end
         ox = ox + tpox;
         tile++;
      end while (!final_tile);
      return count;
   endfunction

   //////////////////////////////
   // stimulus
   //////////////////////////////

   task automatic store_layer(input int idx, input int g_ix, input int g_pox, input int g_k,
                              input int g_s, input int g_p);
      lay_ix[idx]  = g_ix;
      lay_pox[idx] = g_pox;
      lay_k[idx]   = g_k;
      lay_s[idx]   = g_s;
      lay_p[idx]   = g_p;
   endtask

   task automatic run_layer(input int idx);
      int waited;
      ix     = pix_idx_t'(lay_ix[idx]);
      pox    = pix_idx_t'(lay_pox[idx]);
      k      = geom_t'(lay_k[idx]);
      s      = geom_t'(lay_s[idx]);
      p      = geom_t'(lay_p[idx]);
      start  = 1'b1;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
         start = 1'b0;
      end while (!fetch_valid && waited < 50);
      check_value("cycles from start to first fetch_valid", 32'(waited), 32'd3);
      while (!layer_done) begin
         @(negedge clk);
      end
      // walker passes through done before it accepts a new start
      @(negedge clk);
   endtask

   initial begin
      clk           = 1'b0;
      reset         = 1'b1;
      start         = 1'b0;
      ix            = 16'd8;
      pox           = 16'd1;
      k             = 4'd1;
      s             = 4'd1;
      p             = 4'd0;
      seed          = 32'h6cb;
      error_count   = 0;
      checked_count = 0;
      in_layer      = 1'b0;
      plan_ready    = 1'b0;
      // wide row, stride 2 with kernel tail, many tiles
      store_layer(0, 80, 40, 3, 1, 1);
      store_layer(1, 100, 16, 5, 2, 2);
      store_layer(2, 120, 30, 3, 1, 1);
      for (int i = directed_layers; i < num_layers; i++) begin
         lay_ix[i]  = pick_range(8, 200);
         lay_pox[i] = pick_range(1, 48);
         lay_k[i]   = pick_range(1, 7);
         lay_s[i]   = pick_range(1, 2);
         lay_p[i]   = pick_range(0, 3);
      end
      total_segments = 0;
      for (int i = 0; i < num_layers; i++) begin
         total_segments += model_segments(lay_ix[i], lay_pox[i], lay_k[i], lay_s[i],
                                          lay_p[i]);
      end
      watchdog_cycles = total_segments + 20 * num_layers + 10;
      plan_ready      = 1'b1;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      check_value("fetch_valid after reset", 32'(fetch_valid), 32'd0);
      check_value("fetch_bank after reset", 32'(fetch_bank), 32'd0);
      for (int i = 0; i < num_layers; i++) begin
         run_layer(i);
      end
      if (expected.size() != 0) begin
         error_count++;
         $display("error: %0d modeled segments were never fetched", expected.size());
      end
      $display("segments checked: %0d of %0d, errors: %0d", checked_count, total_segments,
               error_count);
      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   //////////////////////////////
   // comparison and watchdog
   //////////////////////////////

   always @(negedge clk) begin
      if (!reset) begin
         if (fetch_valid) begin
            if (expected.size() == 0) begin
               error_count++;
               $display("error at %0t: fetch_valid high with no modeled segment left", $time);
            end else begin
               want_seg = expected.pop_front();
               check_value("fetch_row_start", 32'(fetch_row_start), 32'(want_seg.row_start));
               check_value("fetch_row_end", 32'(fetch_row_end), 32'(want_seg.row_end));
               check_value("fetch_reg_start", 32'(fetch_reg_start), 32'(want_seg.reg_start));
               check_value("fetch_reg_end", 32'(fetch_reg_end), 32'(want_seg.reg_end));
               check_value("fetch_west_pad", 32'(fetch_west_pad), 32'(want_seg.west_pad));
               check_value("fetch_east_pad", 32'(fetch_east_pad), 32'(want_seg.east_pad));
               check_value("fetch_slab", 32'(fetch_slab), 32'(want_seg.slab));
               check_value("fetch_bank", 32'(fetch_bank), 32'(want_seg.bank));
               check_value("tile_end", 32'(tile_end), 32'(want_seg.tile_end));
               check_value("layer_done", 32'(layer_done), 32'(want_seg.layer_done));
               checked_count++;
            end
         end else begin
            if (in_layer) begin
               error_count++;
               $display("error at %0t: fetch_valid dropped inside a layer", $time);
            end
            check_value("tile_end without fetch_valid", 32'(tile_end), 32'd0);
            check_value("layer_done without fetch_valid", 32'(layer_done), 32'd0);
         end
         in_layer = fetch_valid && !layer_done;
      end
   end

   initial begin : watchdog
      wait (plan_ready);
      repeat (watchdog_cycles) @(posedge clk);
      $display("watchdog expired after %0d cycles, the run hung", watchdog_cycles);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

// File: build.f
+incdir+hdl
hdl/conv_fetch_pkg.sv
hdl/conv_tile_walker.sv
hdl/conv_pixels.sv
hdl/row_fetch_issuer.sv
hdl/conv_fetch_top.sv
test/conv_fetch_props.sv
test/conv_fetch_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
TOP       = conv_fetch_tb
FILELIST  = build.f
BUILD_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(BUILD_DIR)
